//--- all.f
+incdir+rtl
rtl/xtr_pkg.sv
rtl/ins_line_align.sv
rtl/mc_step_counter.sv
rtl/mc_sequencer.sv
rtl/mc_rom.sv
rtl/ins_slot_mux.sv
rtl/ins_extract.sv
bench/tb_ins_extract.sv

//--- bench/tb_ins_extract.sv
// Extraction stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module tb_ins_extract
	import xtr_pkg::*;
();

	// All DUT inputs of one cycle, changed together on the falling edge
	typedef struct packed
	{
		logic en;
		logic [`XTR_LINE_BITS-1:0] line;
		pc_address_t pc;
		logic nop;
		logic branchmiss;
		pc_address_t misspc;
		logic hirq;
		logic [2:0] irq;
		logic [6:0] vect;
		logic [2:0] grp;
	} stim_t;

	// Modelled sequencer state next to the outputs expected after the last enabled edge
	typedef struct packed
	{
		logic run;
		logic [1:0] entry;
		logic [1:0] step;
		ins_group_t ins;
		pc_address_t pc;
		logic nop;
		logic [2:0] grp;
	} model_t;

	localparam int SEQ_TIMEOUT = 64;

	logic clk = 1'b0;
	logic rst_n_i;
	stim_t stim;
	model_t model;
	integer seed = 78213;

	ins_group_t ins_o;
	pc_address_t pc_o;
	logic nop_o;
	logic [2:0] grp_o;
	logic stall_o;

	ins_extract uut
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.en_i(stim.en),
		.line_i(stim.line),
		.pc_i(stim.pc),
		.nop_i(stim.nop),
		.branchmiss_i(stim.branchmiss),
		.misspc_i(stim.misspc),
		.hirq_i(stim.hirq),
		.irq_i(stim.irq),
		.vect_i(stim.vect),
		.grp_i(stim.grp),
		.ins_o(ins_o),
		.pc_o(pc_o),
		.nop_o(nop_o),
		.grp_o(grp_o),
		.stall_o(stall_o)
	);

	// 4 ns clock period
	always #2 clk = ~clk;

	// ======================================================================
	// Reference model
	// ======================================================================

	// Slot k starts 5k bytes past the fetch offset, byte 0 is the low byte of the word
	function automatic ins_word_t slot_word(input stim_t s, input int k);
		ins_word_t w;
		int first;
		first = int'(s.pc[5:0]) + k * `XTR_INS_BYTES;
		for (int b = 0; b < `XTR_INS_BYTES; b++)
		begin
			w[b*8 +: 8] = s.line[(first + b)*8 +: 8];
		end
		return w;
	endfunction

	// Decode sees the raw word plus copies of its four register fields
	function automatic ex_instruction_t with_fields(input ins_word_t w);
		ex_instruction_t x;
		x.ins = w;
		x.aRt = w.Rt;
		x.aRa = w.Ra;
		x.aRb = w.Rb;
		x.aRc = w.Rc;
		return x;
	endfunction

	// ROM slot s at step t of entry e is an add tagged with s, t and e
	function automatic ex_instruction_t rom_slot(input int s, input logic [1:0] t,
		input logic [1:0] e);
		ins_word_t w;
		w = '0;
		w.opcode = OP_ADD;
		w.Rt = 7'(s);
		w.Ra = {5'd0, t};
		w.Rb = {5'd0, e};
		return with_fields(w);
	endfunction

	// Outputs and sequencer state after one enabled edge with inputs s
	function automatic model_t next_model(input stim_t s, input model_t m);
		model_t n;
		ins_word_t w0;
		ins_word_t irq_w;
		logic [`XTR_SLOTS-1:0] kill;
		n = m;
		n.pc = s.pc;
		n.nop = s.nop;
		n.grp = s.grp;
		w0 = slot_word(s, 0);
		irq_w = '0;
		irq_w.opcode = OP_SYS;
		irq_w.Ra = {4'd0, s.irq};
		irq_w.Rb = s.vect;
		irq_w.func = FN_IRQ;
		for (int k = 0; k < `XTR_SLOTS; k++)
		begin
			kill[k] = s.nop ||
				(s.branchmiss && (s.misspc > s.pc + pc_address_t'(k * `XTR_INS_BYTES)));
			// Interrupts only win while idle, a running sequence ignores them
			if (!m.run && s.hirq)
				n.ins[k] = (k == 0) ? with_fields(irq_w) : '0;
			else if (kill[k])
				n.ins[k] = '0;
			else if (m.run)
				n.ins[k] = rom_slot(k, m.step, m.entry);
			else
				n.ins[k] = with_fields(slot_word(s, k));
		end
		if (m.run)
		begin
			if (m.step == m.entry)
				n.run = 1'b0;
			else
				n.step = m.step + 2'd1;
		end
		else if (!s.hirq && w0.opcode == OP_MCALL && !kill[0])
		begin
			n.run = 1'b1;
			n.entry = w0.Ra[1:0];
			n.step = 2'd0;
		end
		return n;
	endfunction

	always @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			model <= '0;
		else if (stim.en)
			model <= next_model(stim, model);
	end

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic stop_failed();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [511:0] actual,
		input logic [511:0] expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			stop_failed();
		end
	endtask

	// Outputs settle well before the next falling edge changes the inputs
	// The model is cleared in reset, so the reset values are compared as well
	always @(posedge clk)
	begin
		#1;
		check_value("ins_o", 512'(ins_o), 512'(model.ins));
		check_value("pc_o", 512'(pc_o), 512'(model.pc));
		check_value("nop_o", 512'(nop_o), 512'(model.nop));
		check_value("grp_o", 512'(grp_o), 512'(model.grp));
		check_value("stall_o", 512'(stall_o), 512'(model.run));
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	// Random line and PC at the given offset, with no call word at slot 0
	function automatic stim_t base_stim(input logic [5:0] off);
		stim_t s;
		logic [31:0] r;
		s = '0;
		for (int i = 0; i < `XTR_LINE_BITS / 32; i++)
		begin
			s.line[i*32 +: 32] = next_rand();
		end
		if (s.line[int'(off)*8 +: 7] == 7'(OP_MCALL))
			s.line[int'(off)*8 +: 7] = 7'(OP_ADD);
		r = next_rand();
		s.pc = {1'b0, r[30:6], off};
		s.en = 1'b1;
		r = next_rand();
		s.irq = r[2:0];
		s.vect = r[9:3];
		s.grp = r[12:10];
		return s;
	endfunction

	// Called at a falling edge and returns at the next one
	task automatic drive(input stim_t s);
		stim = s;
		@(negedge clk);
	endtask

	task automatic sweep_offsets();
		stim_t s;
		logic [31:0] r;
		for (int off = 0; off < 64; off++)
		begin
			s = base_stim(6'(off));
			r = next_rand();
			s.en = (r[1:0] != 2'b00);
			drive(s);
		end
	endtask

	task automatic kill_slots();
		stim_t s;
		logic [31:0] r;
		for (int i = 0; i < 8; i++)
		begin
			s = base_stim(6'(next_rand()));
			s.nop = 1'b1;
			drive(s);
		end
		// Targets 0 to 20 bytes past slot 0 kill anything from no slot to all four
		for (int i = 0; i < 24; i++)
		begin
			s = base_stim(6'(next_rand()));
			r = next_rand();
			s.branchmiss = 1'b1;
			s.misspc = s.pc + pc_address_t'(r[7:0] % 8'd21);
			drive(s);
		end
	endtask

	task automatic raise_irqs();
		stim_t s;
		for (int i = 0; i < 8; i++)
		begin
			s = base_stim(6'(next_rand()));
			s.hirq = 1'b1;
			drive(s);
		end
	endtask

	// Plants a call to the entry, then holds the line while the DUT stalls
	task automatic call_microcode(input logic [1:0] entry, input logic irq_during);
		stim_t s;
		ins_word_t call;
		logic [31:0] r;
		int micro;
		int waited;
		s = base_stim(6'(next_rand()));
		r = next_rand();
		call = '0;
		call.opcode = OP_MCALL;
		call.Rt = r[6:0];
		call.Ra = {r[11:7], entry};
		call.Rb = r[18:12];
		call.Rc = r[25:19];
		call.func = r[30:26];
		s.line[int'(s.pc[5:0])*8 +: `XTR_INS_BITS] = call;
		drive(s);
		micro = 0;
		waited = 0;
		while (stall_o)
		begin
			if (waited >= SEQ_TIMEOUT)
			begin
				$display("Timeout: micro-code sequence for entry %0d did not end", entry);
				stop_failed();
			end
			// Random back-pressure and interrupt requests while the line is held
			r = next_rand();
			s.en = (r[1:0] != 2'b00);
			s.hirq = irq_during & r[2];
			s.irq = r[5:3];
			s.vect = r[12:6];
			s.grp = r[15:13];
			if (s.en)
				micro++;
			waited++;
			drive(s);
		end
		check_value("micro_groups", 512'(micro), 512'(int'(entry) + 1));
		// Back in idle the pending interrupt now takes the group
		if (irq_during)
		begin
			s.en = 1'b1;
			s.hirq = 1'b1;
			drive(s);
		end
	endtask

	initial
	begin
		stim = '0;
		rst_n_i = 1'b0;
		repeat (3) @(negedge clk);
		rst_n_i = 1'b1;
		sweep_offsets();
		kill_slots();
		raise_irqs();
		for (int e = 0; e < `XTR_MC_ENTRIES; e++)
		begin
			call_microcode(2'(e), 1'b0);
		end
		for (int e = `XTR_MC_ENTRIES - 1; e >= 0; e--)
		begin
			call_microcode(2'(e), 1'b1);
		end
		call_microcode(2'd2, 1'b0);
		call_microcode(2'd3, 1'b1);
		sweep_offsets();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/ins_extract.sv
// Instruction extraction stage

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module ins_extract
	import xtr_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic en_i,
	input wire logic [`XTR_LINE_BITS-1:0] line_i,
	input wire pc_address_t pc_i,
	input wire logic nop_i,
	input wire logic branchmiss_i,
	input wire pc_address_t misspc_i,
	input wire logic hirq_i,
	input wire logic [2:0] irq_i,
	input wire logic [6:0] vect_i,
	input wire logic [2:0] grp_i,
	output ins_group_t ins_o,
	output pc_address_t pc_o,
	output logic nop_o,
	output logic [2:0] grp_o,
	output logic stall_o
);

	// ======================================================================
	// Stage wiring
	// ======================================================================

	// Aligned line and per-slot information
	ins_group_t group_c;
	pc_address_t [`XTR_SLOTS-1:0] slot_pc_c;
	logic [`XTR_SLOTS-1:0] slot_nop_c;
	logic mcall_hit_c;
	logic [$clog2(`XTR_MC_ENTRIES)-1:0] mc_entry_c;

	// Sequencer control and micro-code data
	grp_src_e grp_src;
	logic ctr_load;
	logic ctr_count;
	logic [$clog2(`XTR_MC_MAX_STEPS)-1:0] step;
	logic last;
	ins_group_t mc_group;

	ins_line_align u_align
	(
		.line_i(line_i),
		.pc_i(pc_i),
		.nop_i(nop_i),
		.branchmiss_i(branchmiss_i),
		.misspc_i(misspc_i),
		.group_o(group_c),
		.slot_pc_o(slot_pc_c),
		.slot_nop_o(slot_nop_c),
		.mcall_hit_o(mcall_hit_c),
		.mc_entry_o(mc_entry_c)
	);

	mc_sequencer u_seq
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.en_i(en_i),
		.hirq_i(hirq_i),
		.mcall_hit_i(mcall_hit_c),
		.mc_entry_i(mc_entry_c),
		.last_i(last),
		.grp_src_o(grp_src),
		.ctr_load_o(ctr_load),
		.ctr_count_o(ctr_count),
		.stall_o(stall_o)
	);

	mc_step_counter u_step
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.en_i(en_i),
		.load_i(ctr_load),
		.count_i(ctr_count),
		.entry_i(mc_entry_c),
		.step_o(step),
		.last_o(last)
	);

	// The call line is held during a run, so its entry field stays valid
	mc_rom u_rom
	(
		.entry_i(mc_entry_c),
		.step_i(step),
		.group_o(mc_group)
	);

	ins_slot_mux u_mux
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.en_i(en_i),
		.grp_src_i(grp_src),
		.slot_nop_i(slot_nop_c),
		.line_group_i(group_c),
		.mc_group_i(mc_group),
		.irq_i(irq_i),
		.vect_i(vect_i),
		.pc_i(slot_pc_c[0]),
		.nop_i(nop_i),
		.grp_i(grp_i),
		.ins_o(ins_o),
		.pc_o(pc_o),
		.nop_o(nop_o),
		.grp_o(grp_o)
	);

endmodule

`default_nettype wire

//--- rtl/ins_line_align.sv
// Cache line alignment and slot split

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module ins_line_align
	import xtr_pkg::*;
(
	input wire logic [`XTR_LINE_BITS-1:0] line_i,
	input wire pc_address_t pc_i,
	input wire logic nop_i,
	input wire logic branchmiss_i,
	input wire pc_address_t misspc_i,
	output ins_group_t group_o,
	output pc_address_t [`XTR_SLOTS-1:0] slot_pc_o,
	output logic [`XTR_SLOTS-1:0] slot_nop_o,
	output logic mcall_hit_o,
	output logic [$clog2(`XTR_MC_ENTRIES)-1:0] mc_entry_o
);

	logic [`XTR_LINE_BITS-1:0] line_aligned;
	ins_word_t [`XTR_SLOTS-1:0] word_c;

	// Bring the byte at the fetch offset down to bit 0 of the line
	assign line_aligned = line_i >> {pc_i[5:0], 3'd0};

	// Instructions are packed back to back, so slot k starts k words up
	always_comb
	begin
		for (int k = 0; k < `XTR_SLOTS; k++)
		begin
			word_c[k] = ins_word_t'(line_aligned[k*`XTR_INS_BITS +: `XTR_INS_BITS]);
		end
	end

	// Decode copies the register fields out of the raw word
	always_comb
	begin
		for (int k = 0; k < `XTR_SLOTS; k++)
		begin
			group_o[k].ins = word_c[k];
			group_o[k].aRt = word_c[k].Rt;
			group_o[k].aRa = word_c[k].Ra;
			group_o[k].aRb = word_c[k].Rb;
			group_o[k].aRc = word_c[k].Rc;
		end
	end

	// Each slot sits a fixed number of bytes past the group PC
	// A branch miss kills every slot that lies before the target
	always_comb
	begin
		for (int k = 0; k < `XTR_SLOTS; k++)
		begin
			slot_pc_o[k] = pc_i + pc_address_t'(k * `XTR_INS_BYTES);
			slot_nop_o[k] = nop_i || (branchmiss_i && (misspc_i > slot_pc_o[k]));
		end
	end

	// A live micro-code call in slot 0 names its entry point in Ra
	assign mcall_hit_o = (word_c[0].opcode == OP_MCALL) && !slot_nop_o[0];
	assign mc_entry_o = word_c[0].Ra[$clog2(`XTR_MC_ENTRIES)-1:0];

endmodule

`default_nettype wire

//--- rtl/ins_slot_mux.sv
// Registered slot source selection

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module ins_slot_mux
	import xtr_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic en_i,
	input wire grp_src_e grp_src_i,
	input wire logic [`XTR_SLOTS-1:0] slot_nop_i,
	input wire ins_group_t line_group_i,
	input wire ins_group_t mc_group_i,
	input wire logic [2:0] irq_i,
	input wire logic [6:0] vect_i,
	input wire pc_address_t pc_i,
	input wire logic nop_i,
	input wire logic [2:0] grp_i,
	output ins_group_t ins_o,
	output pc_address_t pc_o,
	output logic nop_o,
	output logic [2:0] grp_o
);

	ins_word_t irq_word;
	ex_instruction_t irq_ins;
	ins_group_t group_d;

	// The interrupt system instruction carries the level in Ra and the vector in Rb
	always_comb
	begin
		irq_word = '0;
		irq_word.opcode = OP_SYS;
		irq_word.Ra = regno_t'(irq_i);
		irq_word.Rb = regno_t'(vect_i);
		irq_word.func = FN_IRQ;
		irq_ins.ins = irq_word;
		irq_ins.aRt = irq_word.Rt;
		irq_ins.aRa = irq_word.Ra;
		irq_ins.aRb = irq_word.Rb;
		irq_ins.aRc = irq_word.Rc;
	end

	// ======================================================================
	// Per-slot priority, interrupt first, then NOP, then the group source
	// ======================================================================

	always_comb
	begin
		for (int k = 0; k < `XTR_SLOTS; k++)
		begin
			if (grp_src_i == SRC_IRQ)
				group_d[k] = (k == 0) ? irq_ins : '0;
			else if (slot_nop_i[k])
				group_d[k] = '0;
			else if (grp_src_i == SRC_MCODE)
				group_d[k] = mc_group_i[k];
			else
				group_d[k] = line_group_i[k];
		end
	end

	// Everything handed to decode moves together on an enabled edge
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ins_o <= '0;
			pc_o <= '0;
			nop_o <= 1'b0;
			grp_o <= '0;
		end
		else if (en_i)
		begin
			ins_o <= group_d;
			pc_o <= pc_i;
			nop_o <= nop_i;
			grp_o <= grp_i;
		end
	end

	// The sequencer's interrupt choice must reach decode as a system instruction
	a_irq_slot0: assert property (@(posedge clk) disable iff (!rst_n_i)
		en_i && grp_src_i == SRC_IRQ |=> ins_o[0].ins.opcode == OP_SYS)
		else $error("ins_slot_mux: interrupt group without OP_SYS in slot 0");

endmodule

`default_nettype wire

//--- rtl/mc_rom.sv
// Micro-code group ROM

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module mc_rom
	import xtr_pkg::*;
(
	input wire logic [$clog2(`XTR_MC_ENTRIES)-1:0] entry_i,
	input wire logic [$clog2(`XTR_MC_MAX_STEPS)-1:0] step_i,
	output ins_group_t group_o
);

	// Every ROM slot is an add that tags slot, step and entry in its registers
	function automatic ins_group_t rom_row(input logic [1:0] e, input logic [1:0] t);
		ins_group_t g;
		g = '0;
		for (int s = 0; s < `XTR_SLOTS; s++)
		begin
			g[s].ins.opcode = OP_ADD;
			g[s].ins.Rt = regno_t'(s);
			g[s].ins.Ra = regno_t'(t);
			g[s].ins.Rb = regno_t'(e);
			g[s].aRt = g[s].ins.Rt;
			g[s].aRa = g[s].ins.Ra;
			g[s].aRb = g[s].ins.Rb;
			g[s].aRc = g[s].ins.Rc;
		end
		return g;
	endfunction

	// Rows are indexed by entry then step, steps past an entry's length stay empty
	always_comb
	begin
		case ({entry_i, step_i})
			4'b00_00:
				group_o = rom_row(entry_i, step_i);
			4'b01_00, 4'b01_01:
				group_o = rom_row(entry_i, step_i);
			4'b10_00, 4'b10_01, 4'b10_10:
				group_o = rom_row(entry_i, step_i);
			4'b11_00, 4'b11_01, 4'b11_10, 4'b11_11:
				group_o = rom_row(entry_i, step_i);
			default:
				group_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/mc_sequencer.sv
// Micro-code sequencer FSM

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module mc_sequencer
	import xtr_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic en_i,
	input wire logic hirq_i,
	input wire logic mcall_hit_i,
	input wire logic [$clog2(`XTR_MC_ENTRIES)-1:0] mc_entry_i,
	input wire logic last_i,
	output grp_src_e grp_src_o,
	output logic ctr_load_o,
	output logic ctr_count_o,
	output logic stall_o
);

	mc_state_e state_q;
	mc_state_e state_d;

	// ======================================================================
	// Next state and source selection
	// ======================================================================

	always_comb
	begin
		grp_src_o = SRC_LINE;
		ctr_load_o = 1'b0;
		ctr_count_o = 1'b0;
		stall_o = 1'b0;
		state_d = state_q;
		case (state_q)
			MC_IDLE:
			begin
				// An interrupt replaces the whole group, so a call under it is lost
				if (hirq_i)
					grp_src_o = SRC_IRQ;
				else if (mcall_hit_i)
				begin
					// The call group itself goes out as fetched
					ctr_load_o = 1'b1;
					state_d = MC_RUN;
				end
			end
			MC_RUN:
			begin
				// Fetch is held while the ROM feeds decode, interrupts wait
				grp_src_o = SRC_MCODE;
				stall_o = 1'b1;
				// The step stops at the last group so it never passes the entry
				ctr_count_o = !last_i;
				if (last_i)
					state_d = MC_IDLE;
			end
			default:
				state_d = MC_IDLE;
		endcase
	end

	// State only moves when the pipeline advances
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			state_q <= MC_IDLE;
		else if (en_i)
			state_q <= state_d;
	end

	// A taken load starts a run, and no second load can happen inside it
	a_no_load_in_run: assert property (@(posedge clk) disable iff (!rst_n_i)
		ctr_load_o && en_i |=> state_q == MC_RUN && !ctr_load_o)
		else $error("mc_sequencer: counter load while a sequence runs");

	// The counter has to see a one-group sequence as ending at once
	a_load_last: assert property (@(posedge clk) disable iff (!rst_n_i)
		ctr_load_o && en_i |=> last_i == ($past(mc_entry_i) == '0))
		else $error("mc_sequencer: last step flag does not match the loaded entry");

endmodule

`default_nettype wire

//--- rtl/mc_step_counter.sv
// Micro-code step counter

`timescale 1ns/1ps
`default_nettype none

`include "xtr_cfg.svh"

module mc_step_counter
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic en_i,
	input wire logic load_i,
	input wire logic count_i,
	input wire logic [$clog2(`XTR_MC_ENTRIES)-1:0] entry_i,
	output logic [$clog2(`XTR_MC_MAX_STEPS)-1:0] step_o,
	output logic last_o
);

	logic [$clog2(`XTR_MC_ENTRIES)-1:0] entry_q;
	logic [$clog2(`XTR_MC_MAX_STEPS)-1:0] step_q;

	// A load wins over a count, a new sequence always starts at step 0
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			entry_q <= '0;
			step_q <= '0;
		end
		else if (en_i)
		begin
			if (load_i)
			begin
				entry_q <= entry_i;
				step_q <= '0;
			end
			else if (count_i)
				step_q <= step_q + 1'b1;
		end
	end

	assign step_o = step_q;

	// Entry e runs e+1 groups, so the final step number equals e
	assign last_o = (step_q == entry_q);

	// The sequencer must stop counting once the last step is reached
	a_step_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		step_q <= entry_q)
		else $error("mc_step_counter: step %0d ran past entry %0d", step_q, entry_q);

endmodule

`default_nettype wire

//--- rtl/xtr_cfg.svh
// Extraction stage configuration

`ifndef XTR_CFG_SVH
`define XTR_CFG_SVH

// ======================================================================
// Cache line and instruction geometry
// ======================================================================

// One instruction cache line in bits
`define XTR_LINE_BITS 1024
// Width of a single instruction word
`define XTR_INS_BITS 40
// Byte distance between two consecutive slots
`define XTR_INS_BYTES 5
// Instructions handed to decode per cycle
`define XTR_SLOTS 4
// Width of one architectural register field
`define XTR_REG_BITS 7

// ======================================================================
// Micro-code limits
// ======================================================================

// Entry points in the micro-code store
`define XTR_MC_ENTRIES 4
// Longest sequence in groups, entry e runs e+1 of them
`define XTR_MC_MAX_STEPS 4

`endif

//--- rtl/xtr_pkg.sv
// Extraction stage types

`default_nettype none

`include "xtr_cfg.svh"

package xtr_pkg;

	// Byte address of an instruction
	typedef logic [31:0] pc_address_t;

	// Architectural register number
	typedef logic [`XTR_REG_BITS-1:0] regno_t;

	// Opcodes the stage itself cares about, anything else passes through
	typedef enum logic [6:0]
	{
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd2,
		OP_SYS   = 7'd8,
		OP_MCALL = 7'd9
	} opcode_e;

	// Func code that marks a system instruction as a hardware interrupt
	localparam logic [4:0] FN_IRQ = 5'd5;

	// Raw instruction word, opcode sits in the low bits
	typedef struct packed
	{
		logic [4:0] func;
		regno_t Rc;
		regno_t Rb;
		regno_t Ra;
		regno_t Rt;
		opcode_e opcode;
	} ins_word_t;

	// Instruction as decode expects it, raw word plus the register fields
	typedef struct packed
	{
		ins_word_t ins;
		regno_t aRt;
		regno_t aRa;
		regno_t aRb;
		regno_t aRc;
	} ex_instruction_t;

	// One fetch group, slot 0 occupies the low bits
	typedef ex_instruction_t [`XTR_SLOTS-1:0] ins_group_t;

	// Micro-code sequencer states
	typedef enum logic
	{
		MC_IDLE,
		MC_RUN
	} mc_state_e;

	// Where the group registered to decode comes from
	typedef enum logic [1:0]
	{
		SRC_LINE,
		SRC_IRQ,
		SRC_MCODE
	} grp_src_e;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the extraction stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ins_extract
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_ins_extract > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
	echo "Simulation result: PASS"
	exit 0
else
	echo "Simulation result: FAIL"
	exit 1
fi
